// ==== tests/sound_board_testdata.txt ====
# Ops, fields in hex: T num name | L load_addr data | W addr data | R addr expected
# C cmd | A audio audio_aux | Q max_cycles | I irq_n | N cycles | X addr (read, no check)
T 1 rom_load_read
L C000 11
L C7FF 12
L C800 21
L CFFF 22
L D000 31
L D7FF 32
L D800 41
L DFFF 42
L BFFF 99
L E000 88
R 6000 11
R 67FF 12
R 6800 21
R 6FFF 22
R 7000 31
R 77FF 32
R 7800 41
R 7FFF 42
T 2 dac_latches
W 1000 5A
W 3000 A5
A 5A A5
R 1000 00
R 3000 00
R 2000 00
R 4000 00
W 6000 77
W 2000 FF
A 5A A5
R 6000 11
T 3 riot_ram
W 0000 01
W 0042 42
W 007F 7F
W 0004 C3
R 0000 01
R 0042 42
R 007F 7F
R 0004 C3
R 0200 3F
T 4 command_jumpers
C 0F
R 0200 B0
C 3F
R 0200 80
C 00
R 0200 3F
C 15
R 0200 2A
R 0202 DA
T 5 timer_irq
I 1
W 0218 20
Q 22
I 0
R 0205 80
X 0204
I 1
W 0210 10
N 20
I 1
R 0205 80
T 6 back_pressure
W 1000 33
A 33 A5
R 6800 21
R 7FFF 42
R 0042 42
R 0202 DA
W 0010 5E
R 0010 5E

// ==== files.f ====
verilog/sound_pkg.sv
verilog/program_rom.sv
verilog/sound_riot.sv
verilog/board_bus.sv
verilog/sound_board_top.sv
tests/sound_board_checker.sv
tests/sound_board_tb.sv

// ==== Bender.yml ====
package:
  name: sound_board

sources:
  - files:
      - verilog/sound_pkg.sv
      - verilog/program_rom.sv
      - verilog/sound_riot.sv
      - verilog/board_bus.sv
      - verilog/sound_board_top.sv
  - target: test
    files:
      - tests/sound_board_checker.sv
      - tests/sound_board_tb.sv

// ==== tests/sound_board_tb.sv ====
`timescale 1ns/10ps

module sound_board_tb;
  import sound_pkg::*;

  // About 60 bus ops of up to 14 cycles plus timer waits stay well below this
  localparam int CYCLE_LIMIT = 2000;

  logic         clk;
  logic         rst_n;
  logic         cen;
  logic         req;
  logic         rw_n;
  addr_t        addr;
  data_t        wdata;
  cmd_t         cmd;
  logic         rom_init;
  load_addr_t   rom_init_address;
  data_t        rom_init_data;
  logic         ack;
  data_t        rdata;
  data_t        audio;
  data_t        audio_aux;
  logic         irq_n;

  integer       seed = 32'haf66_8723;
  integer       cycles = 0;
  integer       strobe_cycle = 0;  // Edge that ended the last BUS_ACCESS
  integer       errors = 0;
  integer       test_errors = 0;
  integer       checks = 0;
  integer       tests_done = 0;

  sound_board_top #(.ROM_LOAD_BASE(18'hC000), .JUMPERS(6'h25)) UUT (
    .clk(clk), .rst_n(rst_n), .cen(cen), .req(req), .rw_n(rw_n), .addr(addr),
    .wdata(wdata), .cmd(cmd), .rom_init(rom_init), .rom_init_address(rom_init_address),
    .rom_init_data(rom_init_data), .ack(ack), .rdata(rdata), .audio(audio),
    .audio_aux(audio_aux), .irq_n(irq_n)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      errors = errors + 1;
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
    checks = checks + 1;
    if (expected !== actual) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      errors = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  // Full four-phase access with a random hold of req after ack
  task automatic bus_access(input logic is_read, input addr_t a, input data_t wd,
                            output data_t rd);
    integer extra;
    extra = $unsigned($random(seed)) % 8;
    @(posedge clk);
    #1;
    req   = 1'b1;
    rw_n  = is_read;
    addr  = a;
    wdata = wd;
    forever begin
      @(posedge clk);
      #1;
      if (ack) break;
    end
    strobe_cycle = cycles - 1;  // Writes land one edge before ack rises
    rd = rdata;
    repeat (extra) begin
      @(posedge clk);
      #1;
      compare("ack", 8'd1, {7'd0, ack});
      if (is_read) begin
        compare("rdata", rd, rdata);  // Must hold while ack is up
      end
    end
    req = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!ack) break;
    end
  endtask

  task automatic load_byte(input load_addr_t la, input data_t d);
    @(posedge clk);
    #1;
    rom_init         = 1'b1;
    rom_init_address = la;
    rom_init_data    = d;
    @(posedge clk);
    #1;
    rom_init = 1'b0;
  endtask

  task automatic wait_irq(input integer limit);
    while (irq_n && (cycles - strobe_cycle) < limit) begin
      @(posedge clk);
      #1;
    end
    if (irq_n) begin
      $display("irq_n did not fall within %0d cycles of the timer load", limit);
      errors = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  task automatic report_test(input integer num, input logic [8*32-1:0] name);
    if (test_errors == 0) begin
      $display("Test %0d %0s: ok", num, name);
    end else begin
      $display("Test %0d %0s: failed with %0d mismatches", num, name, test_errors);
    end
    tests_done = tests_done + 1;
    test_errors = 0;
  endtask

  initial begin
    integer             fd;
    integer             rc;
    integer             num;
    integer             cur_num;
    logic               have_test;
    logic [7:0]         op;
    logic [31:0]        f1;
    logic [31:0]        f2;
    logic [8*32-1:0]    name;
    logic [8*32-1:0]    cur_name;
    logic [8*128-1:0]   line;
    data_t              rd;

    clk = 1'b0;
    rst_n = 1'b0;
    cen = 1'b1;  // Timer runs at full rate
    req = 1'b0;
    rw_n = 1'b1;
    addr = '0;
    wdata = '0;
    cmd = '0;
    rom_init = 1'b0;
    rom_init_address = '0;
    rom_init_data = '0;
    have_test = 1'b0;
    cur_num = 0;
    cur_name = "";

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("tests/sound_board_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file");
      errors = errors + 1;
    end else begin
      while (!$feof(fd)) begin
        rc = $fscanf(fd, " %c", op);
        if (rc == 1) begin
          case (op)
            "#": rc = $fgets(line, fd);
            "T": begin
              rc = $fscanf(fd, "%d %s", num, name);
              if (have_test) begin
                report_test(cur_num, cur_name);
              end
              have_test = 1'b1;
              cur_num = num;
              cur_name = name;
            end
            "L": begin
              rc = $fscanf(fd, "%h %h", f1, f2);
              load_byte(f1[17:0], f2[7:0]);
            end
            "W": begin
              rc = $fscanf(fd, "%h %h", f1, f2);
              bus_access(1'b0, f1[15:0], f2[7:0], rd);
            end
            "R": begin
              rc = $fscanf(fd, "%h %h", f1, f2);
              bus_access(1'b1, f1[15:0], 8'd0, rd);
              compare("rdata", f2[7:0], rd);
            end
            "X": begin
              rc = $fscanf(fd, "%h", f1);
              bus_access(1'b1, f1[15:0], 8'd0, rd);
            end
            "C": begin
              rc = $fscanf(fd, "%h", f1);
              @(posedge clk);
              #1;
              cmd = f1[5:0];
            end
            "A": begin
              rc = $fscanf(fd, "%h %h", f1, f2);
              compare("audio", f1[7:0], audio);
              compare("audio_aux", f2[7:0], audio_aux);
            end
            "Q": begin
              rc = $fscanf(fd, "%h", f1);
              wait_irq(f1);
            end
            "I": begin
              rc = $fscanf(fd, "%h", f1);
              compare("irq_n", f1[7:0], {7'd0, irq_n});
            end
            "N": begin
              rc = $fscanf(fd, "%h", f1);
              repeat (f1) @(posedge clk);
              #1;
            end
            default: begin
              $display("Unknown op in test data: %c", op);
              errors = errors + 1;
              test_errors = test_errors + 1;
            end
          endcase
        end
      end
      $fclose(fd);
      if (have_test) begin
        report_test(cur_num, cur_name);
      end
    end

    $display("Done: %0d tests, %0d checks, %0d mismatches", tests_done, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tests/sound_board_checker.sv ====
`timescale 1ns/10ps

module sound_board_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req,
  input logic                  ack,
  input sound_pkg::bus_state_t state,
  input sound_pkg::data_t      audio
);
  import sound_pkg::*;

  // ack only answers the request that opened the access
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req) && $past(req, 3))
    else $error("ack rose without req");

  // ack low and FSM in release the cycle after req falls, then idle
  ack_drops: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req) |-> ##1 (!ack && state == BUS_RELEASE) ##1 (state == BUS_IDLE))
    else $error("ack or the bus state did not release after req fell");

  // ack changes on the second edge after the sampling edge, seen one edge later
  ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (state == BUS_IDLE && req) |-> ##3 $rose(ack))
    else $error("ack latency is not two cycles");

  reset_values: assert property (@(posedge clk)
    !rst_n |=> (ack == 1'b0 && audio == '0))
    else $error("ack or audio not cleared by reset");

endmodule

bind board_bus sound_board_checker u_checker (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .ack   (ack),
  .state (state),
  .audio (audio)
);

// ==== verilog/sound_board_top.sv ====
`timescale 1ns/10ps

module sound_board_top #(
  parameter sound_pkg::load_addr_t ROM_LOAD_BASE = 18'hC000,
  parameter logic [5:0]            JUMPERS       = 6'h3f
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cen,
  input  logic                  req,
  input  logic                  rw_n,
  input  sound_pkg::addr_t      addr,
  input  sound_pkg::data_t      wdata,
  input  sound_pkg::cmd_t       cmd,
  input  logic                  rom_init,
  input  sound_pkg::load_addr_t rom_init_address,
  input  sound_pkg::data_t      rom_init_data,
  output logic                  ack,
  output sound_pkg::data_t      rdata,
  output sound_pkg::data_t      audio,
  output sound_pkg::data_t      audio_aux,
  output logic                  irq_n
);
  import sound_pkg::*;

  chip_addr_t chip_addr;
  data_t      rom0_dout;
  data_t      rom1_dout;
  data_t      rom2_dout;
  data_t      rom3_dout;
  data_t      riot_rdata;
  data_t      riot_wdata;
  logic       rom_ce0;
  logic       rom_ce1;
  logic       riot_sel;
  logic       riot_ram_sel;
  logic       riot_we;
  logic [6:0] riot_addr;

  board_bus u_bus (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .rw_n         (rw_n),
    .addr         (addr),
    .wdata        (wdata),
    .rom0_dout    (rom0_dout),
    .rom1_dout    (rom1_dout),
    .rom2_dout    (rom2_dout),
    .rom3_dout    (rom3_dout),
    .riot_rdata   (riot_rdata),
    .ack          (ack),
    .rdata        (rdata),
    .chip_addr    (chip_addr),
    .rom_ce0      (rom_ce0),
    .rom_ce1      (rom_ce1),
    .riot_sel     (riot_sel),
    .riot_addr    (riot_addr),
    .riot_ram_sel (riot_ram_sel),
    .riot_we      (riot_we),
    .riot_wdata   (riot_wdata),
    .audio        (audio),
    .audio_aux    (audio_aux)
  );

  // Bank 0 is chips 0 and 1, bank 1 is chips 2 and 3
  program_rom #(.LOAD_BASE(ROM_LOAD_BASE)) u_rom0 (
    .clk(clk), .ce(rom_ce0), .addr(chip_addr), .rom_init(rom_init),
    .rom_init_address(rom_init_address), .rom_init_data(rom_init_data), .dout(rom0_dout)
  );

  program_rom #(.LOAD_BASE(load_addr_t'(ROM_LOAD_BASE + 1 * ROM_BYTES))) u_rom1 (
    .clk(clk), .ce(rom_ce0), .addr(chip_addr), .rom_init(rom_init),
    .rom_init_address(rom_init_address), .rom_init_data(rom_init_data), .dout(rom1_dout)
  );

  program_rom #(.LOAD_BASE(load_addr_t'(ROM_LOAD_BASE + 2 * ROM_BYTES))) u_rom2 (
    .clk(clk), .ce(rom_ce1), .addr(chip_addr), .rom_init(rom_init),
    .rom_init_address(rom_init_address), .rom_init_data(rom_init_data), .dout(rom2_dout)
  );

  program_rom #(.LOAD_BASE(load_addr_t'(ROM_LOAD_BASE + 3 * ROM_BYTES))) u_rom3 (
    .clk(clk), .ce(rom_ce1), .addr(chip_addr), .rom_init(rom_init),
    .rom_init_address(rom_init_address), .rom_init_data(rom_init_data), .dout(rom3_dout)
  );

  sound_riot #(.JUMPERS(JUMPERS)) u_riot (
    .clk     (clk),
    .rst_n   (rst_n),
    .cen     (cen),     // Paces the timer only
    .sel     (riot_sel),
    .addr    (riot_addr),
    .ram_sel (riot_ram_sel),
    .we      (riot_we),
    .wdata   (riot_wdata),
    .cmd     (cmd),
    .rdata   (riot_rdata),
    .irq_n   (irq_n)
  );

endmodule

// ==== verilog/board_bus.sv ====
`timescale 1ns/10ps

module board_bus (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  rw_n,
  input  sound_pkg::addr_t      addr,
  input  sound_pkg::data_t      wdata,
  input  sound_pkg::data_t      rom0_dout,
  input  sound_pkg::data_t      rom1_dout,
  input  sound_pkg::data_t      rom2_dout,
  input  sound_pkg::data_t      rom3_dout,
  input  sound_pkg::data_t      riot_rdata,
  output logic                  ack,
  output sound_pkg::data_t      rdata,
  output sound_pkg::chip_addr_t chip_addr,
  output logic                  rom_ce0,
  output logic                  rom_ce1,
  output logic                  riot_sel,
  output logic [6:0]            riot_addr,
  output logic                  riot_ram_sel,
  output logic                  riot_we,
  output sound_pkg::data_t      riot_wdata,
  output sound_pkg::data_t      audio,
  output sound_pkg::data_t      audio_aux
);
  import sound_pkg::*;

  bus_state_t state;
  bus_state_t state_next;
  logic [2:0] target;
  logic       access;
  logic       wr_strobe;
  data_t      read_mux;

  assign target    = addr[14:12];  // Same decode as the board's 74LS138
  assign access    = (state == BUS_ACCESS);
  assign wr_strobe = access && !rw_n;

  always_comb begin
    state_next = state;
    case (state)
      BUS_IDLE: begin
        if (req) begin
          state_next = BUS_ACCESS;
        end
      end
      BUS_ACCESS: begin
        state_next = BUS_ACK;
      end
      BUS_ACK: begin
        if (!req) begin
          state_next = BUS_RELEASE;
        end
      end
      default: begin
        state_next = BUS_IDLE;
      end
    endcase
  end

  // ack follows req while in BUS_ACK, so it rises one cycle into the state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= BUS_IDLE;
      ack   <= 1'b0;
    end else begin
      state <= state_next;
      ack   <= (state == BUS_ACK) && req;
    end
  end

  // Read strobes and RIOT side
  assign chip_addr    = addr[10:0];
  assign rom_ce0      = access && rw_n && (target == SEL_ROM0);
  assign rom_ce1      = access && rw_n && (target == SEL_ROM1);
  assign riot_sel     = access && (target == SEL_RIOT);
  assign riot_addr    = addr[6:0];
  assign riot_ram_sel = !addr[9];  // RS_n on the chip
  assign riot_we      = !rw_n;
  assign riot_wdata   = wdata;

  always_comb begin
    case (target)
      SEL_ROM0: read_mux = addr[11] ? rom1_dout : rom0_dout;
      SEL_ROM1: read_mux = addr[11] ? rom3_dout : rom2_dout;
      SEL_RIOT: read_mux = riot_rdata;
      default:  read_mux = '0;  // DACs are write only
    endcase
  end

  // Captured once, then held steady while ack is up
  always_ff @(posedge clk) begin
    if ((state == BUS_ACK) && !ack) begin
      rdata <= read_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      audio     <= '0;
      audio_aux <= '0;
    end else if (wr_strobe) begin
      if (target == SEL_DAC0) begin
        audio <= wdata;
      end
      if (target == SEL_DAC1) begin
        audio_aux <= wdata;
      end
    end
  end

endmodule

// ==== verilog/sound_riot.sv ====
`timescale 1ns/10ps

module sound_riot #(
  parameter logic [5:0] JUMPERS = 6'h3f
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cen,
  input  logic             sel,
  input  logic [6:0]       addr,
  input  logic             ram_sel,
  input  logic             we,
  input  sound_pkg::data_t wdata,
  input  sound_pkg::cmd_t  cmd,
  output sound_pkg::data_t rdata,
  output logic             irq_n
);
  import sound_pkg::*;

  data_t      ram [128];
  data_t      port_a;
  data_t      port_b;
  data_t      io_rdata;
  data_t      timer;
  logic [9:0] presc_cnt;   // cen pulses seen in this interval
  logic [9:0] presc_max;   // Interval length minus one
  logic [9:0] presc_sel;
  logic       flag;
  logic       irq_en;
  logic       io_write;
  logic       io_read;
  logic       timer_write;
  logic       timer_read;

  assign port_a = {&cmd[3:0], 1'b0, ~cmd};
  assign port_b = {1'b1, 1'b1, ~JUMPERS};  // Bit 7 is speech ready, always set

  assign io_write    = sel && we && !ram_sel;
  assign io_read     = sel && !we && !ram_sel;
  assign timer_write = io_write && addr[4];
  assign timer_read  = io_read && (addr[2:0] == 3'd4);

  // Prescale chosen by the low address bits of a timer write
  always_comb begin
    case (addr[1:0])
      2'd0:    presc_sel = 10'd0;     // 1 pulse
      2'd1:    presc_sel = 10'd7;     // 8 pulses
      2'd2:    presc_sel = 10'd63;    // 64 pulses
      default: presc_sel = 10'd1023;  // 1024 pulses
    endcase
  end

  always_comb begin
    case (addr[2:0])
      3'd0:    io_rdata = port_a;
      3'd2:    io_rdata = port_b;
      3'd4:    io_rdata = timer;
      3'd5:    io_rdata = {flag, 7'd0};
      default: io_rdata = '0;  // Direction registers not fitted
    endcase
  end

  always_ff @(posedge clk) begin
    if (sel && we && ram_sel) begin
      ram[addr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (sel && !we) begin
      rdata <= ram_sel ? ram[addr] : io_rdata;
    end
  end

  // Interval timer; runs at full rate once it has passed zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer     <= 8'hff;
      presc_cnt <= '0;
      presc_max <= 10'd1023;
      flag      <= 1'b0;
      irq_en    <= 1'b0;
    end else if (timer_write) begin
      timer     <= wdata;
      presc_cnt <= '0;
      presc_max <= presc_sel;
      flag      <= 1'b0;
      irq_en    <= addr[3];  // Interrupt enable
    end else begin
      if (timer_read) begin
        flag <= 1'b0;  // Reading the count acknowledges
      end
      if (cen) begin
        if (presc_cnt == presc_max) begin
          presc_cnt <= '0;
          timer     <= timer - 8'd1;
          if (timer == 8'd0) begin
            flag      <= 1'b1;  // Underflow wins over a same-cycle read
            presc_max <= '0;
          end
        end else begin
          presc_cnt <= presc_cnt + 10'd1;
        end
      end
    end
  end

  assign irq_n = !(flag && irq_en);

endmodule

// ==== verilog/program_rom.sv ====
`timescale 1ns/10ps

module program_rom #(
  parameter sound_pkg::load_addr_t LOAD_BASE = 18'hC000
) (
  input  logic                  clk,
  input  logic                  ce,
  input  sound_pkg::chip_addr_t addr,
  input  logic                  rom_init,
  input  sound_pkg::load_addr_t rom_init_address,
  input  sound_pkg::data_t      rom_init_data,
  output sound_pkg::data_t      dout
);
  import sound_pkg::*;

  data_t      mem [ROM_BYTES];
  load_addr_t load_offset;
  logic       load_hit;

  // Offset into this chip's window of the load space
  assign load_offset = rom_init_address - LOAD_BASE;
  assign load_hit    = rom_init && (rom_init_address >= LOAD_BASE) &&
                       (load_offset < load_addr_t'(ROM_BYTES));

  always_ff @(posedge clk) begin
    if (load_hit) begin
      mem[load_offset[10:0]] <= rom_init_data;  // One byte per cycle
    end
  end

  // Registered read, holds while the chip is not enabled
  always_ff @(posedge clk) begin
    if (ce) begin
      dout <= mem[addr];
    end
  end

endmodule

// ==== verilog/sound_pkg.sv ====
package sound_pkg;

  typedef logic [15:0] addr_t;       // Processor address
  typedef logic [7:0]  data_t;       // One bus byte
  typedef logic [17:0] load_addr_t;  // ROM load address
  typedef logic [5:0]  cmd_t;        // Sound command from main board
  typedef logic [10:0] chip_addr_t;  // Byte inside one ROM chip

  // Size of one program ROM chip
  localparam int ROM_BYTES = 2048;

  // Target codes on address bits 14 to 12
  localparam logic [2:0] SEL_RIOT = 3'd0;  // RAM, ports, timer
  localparam logic [2:0] SEL_DAC0 = 3'd1;  // Main audio latch
  localparam logic [2:0] SEL_DAC1 = 3'd3;  // Aux audio latch
  localparam logic [2:0] SEL_ROM0 = 3'd6;  // Lower ROM bank
  localparam logic [2:0] SEL_ROM1 = 3'd7;  // Upper ROM bank

  // Request/acknowledge sequence of one bus access
  typedef enum logic [1:0] {
    BUS_IDLE,     // Waiting for req
    BUS_ACCESS,   // Strobes out, writes land
    BUS_ACK,      // ack held until req drops
    BUS_RELEASE   // ack low, back to idle
  } bus_state_t;

endpackage
